/* Bender.yml */
package:
  name: rv_subset_core

sources:
  - files:
      - rtl/rv_subset_pkg.sv
      - rtl/instr_mem.sv
      - rtl/imem_arbiter.sv
      - rtl/fetch_unit.sv
      - rtl/exec_unit.sv
      - rtl/reg_file.sv
      - rtl/rv_subset_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rv_subset_sva.sv
      - tests/tb_rv_subset.sv

/* build.f */
rtl/rv_subset_pkg.sv
rtl/instr_mem.sv
rtl/imem_arbiter.sv
rtl/fetch_unit.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/rv_subset_core.sv
tests/tb_clock_gen.sv
tests/rv_subset_sva.sv
tests/tb_rv_subset.sv

/* rtl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic                               rdata_valid_i,
  input  rv_subset_pkg::instr_u              instr_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     pc_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     rs2_data_i,
  output rv_subset_pkg::reg_idx_t            rs1_o,
  output rv_subset_pkg::reg_idx_t            rs2_o,
  output logic                               wb_we_o,
  output rv_subset_pkg::reg_idx_t            wb_rd_o,
  output logic [rv_subset_pkg::XLEN-1:0]     wb_data_o,
  output logic                               pc_we_o,
  output logic [rv_subset_pkg::XLEN-1:0]     next_pc_o,
  output logic                               retire_o,
  output logic                               illegal_o
);

  localparam int XLEN = rv_subset_pkg::XLEN;

  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] next_pc;
  logic            legal;
  logic            wr;

  //////////////////////////////////////////////////////////////////////
  // Fields and immediates
  //////////////////////////////////////////////////////////////////////

  assign raw = instr_i;

  // Source indices sit at the same place in every format
  assign rs1_o = instr_i.r_fields.rs1;
  assign rs2_o = instr_i.r_fields.rs2;

  // I immediate, sign extended
  assign imm_i = {{20{instr_i.i_fields.imm12[11]}}, instr_i.i_fields.imm12};
  // B immediate, bit 0 implicit
  assign imm_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  // J immediate, bit 0 implicit
  assign imm_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

  // Link value and fall-through target
  assign pc_plus4 = pc_i + rv_subset_pkg::PC_STEP;

  //////////////////////////////////////////////////////////////////////
  // Decode, ALU and next PC
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    legal   = 1'b0;
    wr      = 1'b0;
    result  = '0;
    next_pc = pc_plus4;
    case (instr_i.r_fields.opcode)
      rv_subset_pkg::OPCODE_ALUR: begin
        if (instr_i.r_fields.funct3 == rv_subset_pkg::F3_ADD_SUB &&
            instr_i.r_fields.funct7 == rv_subset_pkg::F7_SUB) begin
          legal  = 1'b1;
          wr     = 1'b1;
          result = rs1_data_i - rs2_data_i;
        end else if (instr_i.r_fields.funct3 == rv_subset_pkg::F3_OR &&
                     instr_i.r_fields.funct7 == rv_subset_pkg::F7_OR) begin
          legal  = 1'b1;
          wr     = 1'b1;
          result = rs1_data_i | rs2_data_i;
        end
      end
      rv_subset_pkg::OPCODE_ALUI: begin
        // ADDI only
        if (instr_i.i_fields.funct3 == rv_subset_pkg::F3_ADDI) begin
          legal  = 1'b1;
          wr     = 1'b1;
          result = rs1_data_i + imm_i;
        end
      end
      rv_subset_pkg::OPCODE_BRANCH: begin
        // BEQ, no write-back
        if (instr_i.r_fields.funct3 == rv_subset_pkg::F3_BEQ) begin
          legal = 1'b1;
          if (rs1_data_i == rs2_data_i) begin
            next_pc = pc_i + imm_b;
          end
        end
      end
      rv_subset_pkg::OPCODE_JAL: begin
        legal   = 1'b1;
        wr      = 1'b1;
        result  = pc_plus4;
        next_pc = pc_i + imm_j;
      end
      rv_subset_pkg::OPCODE_JALR: begin
        legal   = 1'b1;
        wr      = 1'b1;
        result  = pc_plus4;
        // Target forced even
        next_pc = (rs1_data_i + imm_i) & ~32'd1;
      end
      default: begin
        // Unsupported encoding, retires as illegal
        legal = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Retire and write-back
  //////////////////////////////////////////////////////////////////////

  // Every valid word retires, illegal ones included
  assign retire_o  = rdata_valid_i;
  assign illegal_o = rdata_valid_i && !legal;
  assign pc_we_o   = rdata_valid_i;
  assign next_pc_o = next_pc;

  // x0 writes dropped here
  assign wb_rd_o   = instr_i.i_fields.rd;
  assign wb_we_o   = rdata_valid_i && wr && (instr_i.i_fields.rd != '0);
  assign wb_data_o = result;

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter logic [rv_subset_pkg::XLEN-1:0] BOOT_ADDR  = '0,
  parameter int                             IMEM_DEPTH = 256
) (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  input  logic                               run_i,
  input  logic                               fetch_gnt_i,
  input  logic                               rdata_valid_i,
  input  logic                               pc_we_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     next_pc_i,
  output logic                               fetch_req_o,
  output logic [$clog2(IMEM_DEPTH)-1:0]      fetch_addr_o,
  output logic [rv_subset_pkg::XLEN-1:0]     pc_o
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [rv_subset_pkg::XLEN-1:0] pc_q;
  // Set from grant until the instruction retires
  logic busy_q;
  // Returned word executed, PC may move
  logic retire_ok;

  assign retire_ok = rdata_valid_i && pc_we_i;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q   <= BOOT_ADDR;
      busy_q <= 1'b0;
    end else begin
      if (fetch_gnt_i) begin
        busy_q <= 1'b1;
      end else if (retire_ok) begin
        busy_q <= 1'b0;
      end
      // One instruction in flight, so PC only moves at retire
      if (retire_ok) begin
        pc_q <= next_pc_i;
      end
    end
  end

  // Request held as a level until granted
  assign fetch_req_o = run_i && !busy_q;
  // Byte PC to word index
  assign fetch_addr_o = pc_q[AW+1:2];
  assign pc_o         = pc_q;

endmodule

`default_nettype wire

/* rtl/imem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module imem_arbiter #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  // Loader side, plain strobe
  input  logic                               load_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0]      load_addr_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     load_data_i,
  // Fetch side, level request
  input  logic                               fetch_req_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0]      fetch_addr_i,
  output logic                               fetch_gnt_o,
  output logic                               rdata_valid_o,
  // Memory port
  output logic                               mem_we_o,
  output logic [$clog2(IMEM_DEPTH)-1:0]      mem_addr_o,
  output logic [rv_subset_pkg::XLEN-1:0]     mem_wdata_o
);

  //////////////////////////////////////////////////////////////////////
  // Fixed priority, loader first
  //////////////////////////////////////////////////////////////////////

  // Fetch only gets the port on idle loader cycles
  assign fetch_gnt_o = fetch_req_i && !load_we_i;

  // Port owner drives the address
  assign mem_addr_o = load_we_i ? load_addr_i : fetch_addr_i;

  // Only the loader ever writes
  assign mem_we_o    = load_we_i;
  assign mem_wdata_o = load_data_i;

  //////////////////////////////////////////////////////////////////////
  // Read return tag
  //////////////////////////////////////////////////////////////////////

  // Granted read comes back one cycle later
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rdata_valid_o <= 1'b0;
    end else begin
      rdata_valid_o <= fetch_gnt_o;
    end
  end

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_mem #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                                  clk_i,
  input  logic                                  we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0]         addr_i,
  input  logic [rv_subset_pkg::XLEN-1:0]        wdata_i,
  output logic [rv_subset_pkg::XLEN-1:0]        rdata_o
);

  localparam int XLEN = rv_subset_pkg::XLEN;

  // Word array, one instruction per entry
  logic [XLEN-1:0] mem_q [IMEM_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Single port access
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      // Loader write lands on this edge
      mem_q[addr_i] <= wdata_i;
    end else begin
      // Registered read, data next cycle
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  input  rv_subset_pkg::reg_idx_t            rs1_i,
  input  rv_subset_pkg::reg_idx_t            rs2_i,
  output logic [rv_subset_pkg::XLEN-1:0]     rs1_data_o,
  output logic [rv_subset_pkg::XLEN-1:0]     rs2_data_o,
  input  logic                               we_i,
  input  rv_subset_pkg::reg_idx_t            rd_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     wd_i
);

  localparam int XLEN     = rv_subset_pkg::XLEN;
  localparam int NUM_REGS = rv_subset_pkg::NUM_REGS;

  // x1 to x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
        regs_q[i] <= '0;
      end else if (we_i && rd_i == i[4:0]) begin
        regs_q[i] <= wd_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Combinational, index 0 reads zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

/* rtl/rv_subset_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_subset_core #(
  parameter logic [rv_subset_pkg::XLEN-1:0] BOOT_ADDR  = '0,
  parameter int                             IMEM_DEPTH = 256
) (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  input  logic                               run_i,
  // Program loader
  input  logic                               load_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0]      load_addr_i,
  input  logic [rv_subset_pkg::XLEN-1:0]     load_data_i,
  // Retire trace
  output logic                               retire_o,
  output logic                               illegal_o,
  output logic [rv_subset_pkg::XLEN-1:0]     retire_pc_o,
  output logic                               wb_we_o,
  output rv_subset_pkg::reg_idx_t            wb_rd_o,
  output logic [rv_subset_pkg::XLEN-1:0]     wb_data_o
);

  localparam int AW   = $clog2(IMEM_DEPTH);
  localparam int XLEN = rv_subset_pkg::XLEN;

  // Fetch request path
  logic            fetch_req;
  logic [AW-1:0]   fetch_addr;
  logic            fetch_gnt;
  logic            rdata_valid;
  // Memory port
  logic            mem_we;
  logic [AW-1:0]   mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic [XLEN-1:0] mem_rdata;
  // Execute loop
  logic            pc_we;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] pc;
  rv_subset_pkg::reg_idx_t rs1;
  rv_subset_pkg::reg_idx_t rs2;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  //////////////////////////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////////////////////////

  imem_arbiter #(.IMEM_DEPTH(IMEM_DEPTH)) u_arbiter (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_gnt_o(fetch_gnt),
    .rdata_valid_o(rdata_valid),
    .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
  );

  instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
    .clk_i(clk_i), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Fetch, execute and registers
  //////////////////////////////////////////////////////////////////////

  fetch_unit #(.BOOT_ADDR(BOOT_ADDR), .IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk_i(clk_i), .rstn_i(rstn_i), .run_i(run_i),
    .fetch_gnt_i(fetch_gnt), .rdata_valid_i(rdata_valid),
    .pc_we_i(pc_we), .next_pc_i(next_pc),
    .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr), .pc_o(pc)
  );

  exec_unit u_exec (
    .rdata_valid_i(rdata_valid), .instr_i(mem_rdata), .pc_i(pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .rs1_o(rs1), .rs2_o(rs2),
    .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
    .pc_we_o(pc_we), .next_pc_o(next_pc),
    .retire_o(retire_o), .illegal_o(illegal_o)
  );

  reg_file u_regs (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(wb_we_o), .rd_i(wb_rd_o), .wd_i(wb_data_o)
  );

  // PC of the retiring instruction, still held until the retire edge
  assign retire_pc_o = pc;

endmodule

`default_nettype wire

/* rtl/rv_subset_pkg.sv */
`default_nettype none

package rv_subset_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN = 32;
  // Architectural register count
  localparam int NUM_REGS = 32;
  // Sequential PC increment in bytes
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // Register index
  typedef logic [4:0] reg_idx_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_ALUR   = 7'b0110011;
  localparam logic [6:0] OPCODE_ALUI   = 7'b0010011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_BEQ     = 3'b000;

  // funct7 values
  localparam logic [6:0] F7_SUB = 7'b0100000;
  localparam logic [6:0] F7_OR  = 7'b0000000;

  //////////////////////////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////////////////////////

  // One word, two decodes
  // B and J immediates are sliced from the raw word instead
  typedef union packed {
    // Register-register layout
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r_fields;
    // Immediate layout, also used by JALR
    struct packed {
      logic [11:0] imm12;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i_fields;
  } instr_u;

endpackage

`default_nettype wire

/* tests/rv_subset_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_subset_sva (
  input logic                    clk_i,
  input logic                    rstn_i,
  input logic                    retire_i,
  input logic                    illegal_i,
  input logic [31:0]             retire_pc_i,
  input logic                    wb_we_i,
  input rv_subset_pkg::reg_idx_t wb_rd_i
);

  // x0 writes never reach the trace port
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (!rstn_i) wb_we_i |-> (wb_rd_i != '0)
  ) else $error("write-back strobe with rd zero");

  // Illegal word still retires, but writes nothing
  a_illegal_retire: assert property (
    @(posedge clk_i) disable iff (!rstn_i) illegal_i |-> (retire_i && !wb_we_i)
  ) else $error("illegal flag without retire or with a write");

  // One instruction in flight, so no back-to-back retires
  a_retire_gap: assert property (
    @(posedge clk_i) disable iff (!rstn_i) retire_i |=> !retire_i
  ) else $error("retire high on two consecutive cycles");

  // PC stays even, JALR clears bit 0
  a_pc_even: assert property (
    @(posedge clk_i) disable iff (!rstn_i) !retire_pc_i[0]
  ) else $error("odd retire PC");

endmodule

bind rv_subset_core rv_subset_sva u_sva (
  .clk_i(clk_i), .rstn_i(rstn_i),
  .retire_i(retire_o), .illegal_i(illegal_o), .retire_pc_i(retire_pc_o),
  .wb_we_i(wb_we_o), .wb_rd_i(wb_rd_o)
);

`default_nettype wire

/* tests/rv_subset_vectors.txt */
// Header: program word count, record count, boot address
// Then program words, then records: pc illegal wb_we rd value
00000016 0000000f 00000000
// Program image, word 0 upward
00500093 00c00113 401101b3 0020e233 00908013 ffd00293 00208463 00318663
00100313 00200313 0020f333 00c003ef 7ff48513 0000006f 02138467 00000000
00000000 00000000 00000000 00000000 404284b3 fc000ee3
// Retire records
00000000 0 1 01 00000005
00000004 0 1 02 0000000c
00000008 0 1 03 00000007
0000000c 0 1 04 0000000d
00000010 0 0 00 00000000
00000014 0 1 05 fffffffd
00000018 0 0 00 00000000
0000001c 0 0 00 00000000
00000028 1 0 00 00000000
0000002c 0 1 07 00000030
00000038 0 1 08 0000003c
00000050 0 1 09 fffffff0
00000054 0 0 00 00000000
00000030 0 1 0a 000007ef
00000034 0 0 00 00000000

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  input  logic reset_req_i,
  output logic clk_o,
  output logic rstn_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset at start, and again on each request
  initial begin
    rstn_o = 1'b0;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk_o);
      rstn_o <= 1'b1;
      @(posedge clk_o);
      while (!reset_req_i) @(posedge clk_o);
      rstn_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_rv_subset.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_subset;

  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0000;
  localparam int          IMEM_DEPTH = 64;
  localparam int          AW         = $clog2(IMEM_DEPTH);
  // Loader noise goes to the top quarter, clear of the program
  localparam int          NOISE_BASE = 48;
  localparam logic [31:0] LFSR_SEED  = 32'h6e306d31;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  // Words ahead of the program image
  localparam int          HDR_WORDS  = 3;

  logic                    clk_i;
  logic                    rstn_i;
  logic                    reset_req;
  logic                    run_i;
  logic                    load_we_i;
  logic [AW-1:0]           load_addr_i;
  logic [31:0]             load_data_i;
  logic                    retire_o;
  logic                    illegal_o;
  logic [31:0]             retire_pc_o;
  logic                    wb_we_o;
  rv_subset_pkg::reg_idx_t wb_rd_o;
  logic [31:0]             wb_data_o;

  // Header, program image, then retire records
  logic [31:0] vec_mem [0:127];
  logic [31:0] lfsr_q;
  logic        check_en;
  int          prog_cnt;
  int          rec_cnt;
  int          rec_idx;
  int          noise_cnt;
  int          noise_max;
  int          cycle_cnt;
  int          cycle_limit = 1000;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk (
    .reset_req_i(reset_req), .clk_o(clk_i), .rstn_o(rstn_i)
  );

  rv_subset_core #(.BOOT_ADDR(BOOT_ADDR), .IMEM_DEPTH(IMEM_DEPTH)) uut (
    .clk_i(clk_i), .rstn_i(rstn_i), .run_i(run_i),
    .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .retire_o(retire_o), .illegal_o(illegal_o), .retire_pc_o(retire_pc_o),
    .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                          $time, name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // LFSR stimulus
  //////////////////////////////////////////////////////////////////////

  // Right-shift Galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ LFSR_TAPS;
    end
    return nxt;
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int count, output logic [31:0] bits);
    int k;
    bits = '0;
    for (k = 0; k < count; k++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace monitor
  //////////////////////////////////////////////////////////////////////

  task automatic compare_record(input int idx);
    int    base;
    string tag;
    base = HDR_WORDS + prog_cnt + 5 * idx;
    tag  = $sformatf(" (record %0d)", idx);
    expect_equal({"retire_pc_o", tag}, vec_mem[base], retire_pc_o);
    expect_equal({"illegal_o", tag}, vec_mem[base + 1], {31'b0, illegal_o});
    expect_equal({"wb_we_o", tag}, vec_mem[base + 2], {31'b0, wb_we_o});
    // rd and value only mean something on a write
    if (vec_mem[base + 2][0]) begin
      expect_equal({"wb_rd_o", tag}, vec_mem[base + 3], {27'b0, wb_rd_o});
      expect_equal({"wb_data_o", tag}, vec_mem[base + 4], wb_data_o);
    end
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (rstn_i && !retire_o) begin
      expect_equal("wb_we_o (idle)", 32'd0, {31'b0, wb_we_o});
    end
    if (rstn_i && check_en && retire_o) begin
      if (rec_idx >= rec_cnt) begin
        abort_run("Core retired an instruction after the last expected record");
      end else begin
        compare_record(rec_idx);
        rec_idx = rec_idx + 1;
      end
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  task automatic wait_reset_release();
    while (!rstn_i) @(posedge clk_i);
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    expect_equal("retire_o (reset)", 32'd0, {31'b0, retire_o});
    expect_equal("illegal_o (reset)", 32'd0, {31'b0, illegal_o});
    expect_equal("wb_we_o (reset)", 32'd0, {31'b0, wb_we_o});
    expect_equal("retire_pc_o (reset)", BOOT_ADDR, retire_pc_o);
  endtask

  task automatic restart_core();
    @(posedge clk_i);
    reset_req <= 1'b1;
    while (rstn_i) @(posedge clk_i);
    reset_req <= 1'b0;
    wait_reset_release();
  endtask

  // Loader strobes, one word per cycle
  task automatic load_program();
    int i;
    for (i = 0; i < prog_cnt; i++) begin
      @(posedge clk_i);
      load_we_i   <= 1'b1;
      load_addr_i <= AW'(i);
      load_data_i <= vec_mem[HDR_WORDS + i];
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic run_phase(input logic noisy);
    logic [31:0]   pick;
    logic [AW-1:0] addr;
    rec_idx  = 0;
    check_en = 1'b1;
    @(posedge clk_i);
    run_i <= 1'b1;
    while (rec_idx < rec_cnt) begin
      @(posedge clk_i);
      load_we_i <= 1'b0;
      if (noisy && rec_idx < rec_cnt && noise_cnt < noise_max) begin
        draw_bits(1, pick);
        if (pick[0]) begin
          draw_bits(4, pick);
          addr = AW'(NOISE_BASE) + AW'(pick[3:0]);
          load_we_i   <= 1'b1;
          load_addr_i <= addr;
          load_data_i <= {4{2'b00, addr}};
          noise_cnt = noise_cnt + 1;
        end
      end
    end
    run_i     <= 1'b0;
    load_we_i <= 1'b0;
    // Stray retires after the last record still get caught
    repeat (4) @(posedge clk_i);
    check_en = 1'b0;
  endtask

  initial begin
    run_i       = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    reset_req   = 1'b0;
    check_en    = 1'b0;
    rec_idx     = 0;
    noise_cnt   = 0;
    lfsr_q      = LFSR_SEED;

    $readmemh("tests/rv_subset_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[1]) || $isunknown(vec_mem[2])) begin
      abort_run("Vector file is missing or has no header");
    end
    prog_cnt = vec_mem[0];
    rec_cnt  = vec_mem[1];
    if (prog_cnt > NOISE_BASE || HDR_WORDS + prog_cnt + 5 * rec_cnt > 128) begin
      abort_run("Vector file does not fit the program or record space");
    end
    if ($isunknown(vec_mem[HDR_WORDS + prog_cnt + 5 * rec_cnt - 1])) begin
      abort_run("Vector file is truncated");
    end
    if (vec_mem[2] !== BOOT_ADDR) begin
      abort_run("Boot address in the vector file differs from the core parameter");
    end
    noise_max   = 2 * rec_cnt;
    // Both phases retire every record
    cycle_limit = 4 * (2 * (2 * rec_cnt) + prog_cnt + noise_max) + 100;

    wait_reset_release();
    check_reset_state();
    load_program();
    run_phase(1'b0);

    // Same program again, now with loader contention
    restart_core();
    check_reset_state();
    run_phase(1'b1);
    if (noise_cnt == 0) begin
      abort_run("No loader writes were issued during the contended run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
